// File: logic/audioPkg.sv
package audioPkg;

  localparam int addrWidth = 10;
  localparam int memDepth = 1024;
  localparam int dataWidth = 8;
  localparam int spiAddrBits = 16;   // address phase length on SPI
  localparam int writeFlagBit = 15;
  localparam int dacMsb = 12;        // 13-bit DAC word in excess 4096
  localparam logic [addrWidth-1:0] sampleLoAddr = 10'd1022;
  localparam logic [addrWidth-1:0] sampleHiAddr = 10'd1023;
  localparam int fetchInterval = 256;

  typedef enum logic {
    opRead  = 1'b0,
    opWrite = 1'b1
  } memOp_t;

  // one memory access as seen by the arbiter
  typedef struct packed {
    memOp_t                 op;
    logic [addrWidth-1:0]   addr;
    logic [dataWidth-1:0]   wdata;
  } memReq_t;

  typedef logic [dacMsb:0] dacWord_t;

endpackage

// File: logic/spiMemBridge.sv
`timescale 1ns/1ps

// mode 0 SPI slave taking a 16-bit address then auto-incrementing data bytes
module spiMemBridge (
  input  logic              clk,
  input  logic              Reset,
  input  logic              sck,
  input  logic              mosi,
  input  logic              ssel,
  output logic              miso,
  output audioPkg::memReq_t request,
  output logic              req,
  input  logic              ack,
  input  logic [7:0]        rdata
);
  import audioPkg::*;

  logic [2:0] sckSync;
  logic [1:0] sselSync;
  logic [1:0] mosiSync;
  logic sckRise;
  logic sckFall;
  logic sselActive;
  logic mosiBit;
  logic step;
  logic [4:0] count;
  logic [4:0] countNext;
  logic writeFlag;
  logic [spiAddrBits-1:0] addrShift;
  logic [spiAddrBits-1:0] addrNext;
  logic [spiAddrBits-1:0] addrIncr;
  logic [dataWidth-1:0] dataIn;
  logic [dataWidth-1:0] byteNext;
  logic [dataWidth-1:0] readData;
  logic [dataWidth-1:0] shiftOut;
  logic issueRead;
  logic issueWrite;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      sckSync <= '0;
      sselSync <= '1;   // select idles high
      mosiSync <= '0;
    end else begin
      sckSync <= {sckSync[1:0], sck};
      sselSync <= {sselSync[0], ssel};
      mosiSync <= {mosiSync[0], mosi};
    end
  end

  assign sckRise = (sckSync[2:1] == 2'b01);
  assign sckFall = (sckSync[2:1] == 2'b10);
  assign sselActive = ~sselSync[1];
  assign mosiBit = mosiSync[1];
  assign step = sselActive & sckRise;

  // 0..15 address bits then 16..23 repeating per data byte
  assign countNext = (count == 5'd23) ? 5'd16 : count + 5'd1;
  assign addrNext = {addrShift[spiAddrBits-2:0], mosiBit};
  assign addrIncr = addrShift + 16'd1;
  assign byteNext = {dataIn[dataWidth-2:0], mosiBit};

  assign issueRead = step & (((count == 5'd15) & ~addrNext[writeFlagBit]) |
                             ((count == 5'd23) & ~writeFlag));
  assign issueWrite = step & (count == 5'd23) & writeFlag;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      count <= '0;
      writeFlag <= 1'b0;
      req <= 1'b0;
      shiftOut <= '0;
    end else begin
      if (issueRead | issueWrite) begin
        req <= 1'b1;
      end else if (ack) begin
        req <= 1'b0;
      end
      if (!sselActive) begin
        count <= '0;
        writeFlag <= 1'b0;
        shiftOut <= '0;
      end else begin
        if (sckRise) begin
          count <= countNext;
          if (count == 5'd15) writeFlag <= addrNext[writeFlagBit];
        end
        if (sckFall) begin
          // new byte starts on the first falling edge after a byte boundary
          shiftOut <= (count == 5'd16) ? readData : {shiftOut[dataWidth-2:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      if (!count[4]) begin
        addrShift <= addrNext;
      end else begin
        dataIn <= byteNext;
        if (count == 5'd23) addrShift <= addrIncr;
      end
    end
    if (issueRead | issueWrite) begin
      request.op <= issueWrite ? opWrite : opRead;
      if (count == 5'd15) begin
        request.addr <= addrNext[addrWidth-1:0];   // first read right after address
      end else if (issueWrite) begin
        request.addr <= addrShift[addrWidth-1:0];
      end else begin
        request.addr <= addrIncr[addrWidth-1:0];   // prefetch next byte
      end
      request.wdata <= byteNext;
    end
    if (ack && request.op == opRead) readData <= rdata;
  end

  assign miso = shiftOut[dataWidth-1];

endmodule

// File: logic/sharedMemory.sv
`timescale 1ns/1ps

// single-port RAM shared by the SPI host and the sample fetcher
module sharedMemory (
  input  logic              clk,
  input  logic              Reset,
  input  audioPkg::memReq_t hostRequest,
  input  logic              hostReq,
  output logic              hostAck,
  input  audioPkg::memReq_t fetchRequest,
  input  logic              fetchReq,
  output logic              fetchAck,
  output logic [7:0]        rdata
);
  import audioPkg::*;

  typedef enum logic [1:0] {
    arbIdle,
    arbServe,
    arbRelease
  } arbState_t;

  arbState_t state;
  logic grantFetch;   // high while the fetcher owns the RAM
  logic lastFetch;    // who was served last
  memReq_t active;
  logic activeReq;
  logic [dataWidth-1:0] mem [memDepth];

  assign active = grantFetch ? fetchRequest : hostRequest;
  assign activeReq = grantFetch ? fetchReq : hostReq;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      state <= arbIdle;
      grantFetch <= 1'b0;
      lastFetch <= 1'b1;
      hostAck <= 1'b0;
      fetchAck <= 1'b0;
    end else begin
      case (state)
        arbIdle: begin
          if (hostReq | fetchReq) begin
            // on a tie the peer not served last wins
            if (hostReq & fetchReq) begin
              grantFetch <= ~lastFetch;
              lastFetch <= ~lastFetch;
            end else begin
              grantFetch <= fetchReq;
              lastFetch <= fetchReq;
            end
            state <= arbServe;
          end
        end
        arbServe: begin
          hostAck <= ~grantFetch;
          fetchAck <= grantFetch;
          state <= arbRelease;
        end
        arbRelease: begin
          if (!activeReq) begin
            hostAck <= 1'b0;
            fetchAck <= 1'b0;
            state <= arbIdle;
          end
        end
        default: state <= arbIdle;
      endcase
    end
  end

  // rdata holds until the next access
  always_ff @(posedge clk) begin
    if (state == arbServe) begin
      if (active.op == opWrite) mem[active.addr] <= active.wdata;
      rdata <= mem[active.addr];
    end
  end

endmodule

// File: logic/sampleFetch.sv
`timescale 1ns/1ps

// pulls the 13-bit audio sample out of memory at a fixed interval
module sampleFetch (
  input  logic               clk,
  input  logic               Reset,
  output audioPkg::memReq_t  request,
  output logic               req,
  input  logic               ack,
  input  logic [7:0]         rdata,
  output audioPkg::dacWord_t sample
);
  import audioPkg::*;

  typedef enum logic [1:0] {
    fetchWait,
    fetchLo,
    fetchHi
  } fetchState_t;

  fetchState_t state;
  logic [$clog2(fetchInterval)-1:0] intervalCount;
  logic [dataWidth-1:0] loByte;

  assign request.op = opRead;
  assign request.addr = (state == fetchHi) ? sampleHiAddr : sampleLoAddr;
  assign request.wdata = '0;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      state <= fetchWait;
      intervalCount <= '0;
      req <= 1'b0;
      sample <= dacWord_t'(1 << dacMsb);   // mid-scale
    end else begin
      case (state)
        fetchWait: begin
          intervalCount <= intervalCount + 1'b1;
          if (intervalCount == ($clog2(fetchInterval))'(fetchInterval - 1)) begin
            req <= 1'b1;
            state <= fetchLo;
          end
        end
        fetchLo: begin
          if (req & ack) begin
            req <= 1'b0;
          end else if (!req & !ack) begin
            req <= 1'b1;   // second handshake once ack is down
            state <= fetchHi;
          end
        end
        fetchHi: begin
          if (req & ack) begin
            req <= 1'b0;
            sample <= {rdata[dacMsb-dataWidth:0], loByte};
            intervalCount <= '0;
            state <= fetchWait;
          end
        end
        default: state <= fetchWait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetchLo && req && ack) loByte <= rdata;
  end

endmodule

// File: logic/sigmaDeltaDac.sv
`timescale 1ns/1ps

// first-order delta-sigma DAC with an excess 4096 input
module sigmaDeltaDac (
  input  logic               clk,
  input  logic               Reset,
  input  audioPkg::dacWord_t sample,
  output logic               audio
);
  import audioPkg::*;

  logic [dacMsb+2:0] deltaB;
  logic [dacMsb+2:0] deltaAdder;
  logic [dacMsb+2:0] sigmaAdder;
  logic [dacMsb+2:0] sigmaLatch;

  // sign of the accumulator fed back as the delta term
  assign deltaB = {sigmaLatch[dacMsb+2], sigmaLatch[dacMsb+2], {(dacMsb+1){1'b0}}};
  assign deltaAdder = {2'b00, sample} + deltaB;
  assign sigmaAdder = deltaAdder + sigmaLatch;

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      sigmaLatch <= {2'b01, {(dacMsb+1){1'b0}}};   // mid value
      audio <= 1'b0;
    end else begin
      sigmaLatch <= sigmaAdder;
      audio <= sigmaLatch[dacMsb+2];
    end
  end

endmodule

// File: logic/audioTop.sv
`timescale 1ns/1ps

module audioTop (
  input  logic clk,
  input  logic Reset,
  input  logic sck,
  input  logic mosi,
  input  logic ssel,
  output logic miso,
  output logic audio
);
  import audioPkg::*;

  memReq_t hostRequest;
  memReq_t fetchRequest;
  logic hostReq;
  logic hostAck;
  logic fetchReq;
  logic fetchAck;
  logic [dataWidth-1:0] memRdata;   // shared by both peers
  dacWord_t sample;

  spiMemBridge spiMemBridge_inst (
    .clk(clk), .Reset(Reset),
    .sck(sck), .mosi(mosi), .ssel(ssel), .miso(miso),
    .request(hostRequest), .req(hostReq), .ack(hostAck), .rdata(memRdata)
  );

  sampleFetch sampleFetch_inst (
    .clk(clk), .Reset(Reset),
    .request(fetchRequest), .req(fetchReq), .ack(fetchAck), .rdata(memRdata),
    .sample(sample)
  );

  sharedMemory sharedMemory_inst (
    .clk(clk), .Reset(Reset),
    .hostRequest(hostRequest), .hostReq(hostReq), .hostAck(hostAck),
    .fetchRequest(fetchRequest), .fetchReq(fetchReq), .fetchAck(fetchAck),
    .rdata(memRdata)
  );

  sigmaDeltaDac sigmaDeltaDac_inst (
    .clk(clk), .Reset(Reset), .sample(sample), .audio(audio)
  );

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ps

// free-running 40 ns clock and power-on reset
module clockGen (
  output logic clk,
  output logic Reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    Reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);   // release away from the active edge
    Reset = 1'b0;
  end

endmodule

// File: testbench/tbAudio.sv
`timescale 1ns/1ps

module tbAudio;
  import audioPkg::*;

  localparam int halfPeriod = 10;   // SCK half period in clk cycles
  localparam int dacWindow = 8192;
  localparam int resetLimit = 100;
  localparam int audioLimit = 1000;

  logic clk;
  logic Reset;
  logic sck;
  logic mosi;
  logic ssel;
  logic miso;
  logic audio;

  integer seed;
  integer fd;
  logic [7:0] txBytes [4];
  logic [7:0] rxBytes [4];
  logic [7:0] expBytes [4];

  clockGen clockGen_inst (.clk(clk), .Reset(Reset));

  audioTop audioTop_inst (
    .clk(clk), .Reset(Reset), .sck(sck), .mosi(mosi), .ssel(ssel),
    .miso(miso), .audio(audio)
  );

  task automatic failRun(input string why);
    $display("%0s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkEqual(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("Mismatch in %0s: expected %0d, actual %0d",
                        testName, expected, actual));
    end
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (Reset !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > resetLimit) failRun("timeout waiting for Reset to drop");
    end
  endtask

  task automatic idleGap();
    int gap;
    gap = 16 + ($random(seed) & 255);   // random offset against the fetch interval
    repeat (gap) @(negedge clk);
  endtask

  // mode 0 with MOSI changing while SCK is low and MISO taken at the rising edge
  task automatic spiBit(input logic bitOut, output logic bitIn);
    mosi = bitOut;
    repeat (halfPeriod) @(negedge clk);
    bitIn = miso;
    sck = 1'b1;
    repeat (halfPeriod) @(negedge clk);
    sck = 1'b0;
  endtask

  task automatic spiTransfer(input logic [15:0] spiAddr, input int nBytes);
    logic bitIn;
    logic [7:0] rx;
    ssel = 1'b0;
    repeat (halfPeriod) @(negedge clk);
    for (int i = 15; i >= 0; i--) begin
      spiBit(spiAddr[i], bitIn);
    end
    for (int b = 0; b < nBytes; b++) begin
      for (int i = 7; i >= 0; i--) begin
        spiBit(txBytes[b][i], bitIn);
        rx[i] = bitIn;
      end
      rxBytes[b] = rx;
    end
    mosi = 1'b0;
    repeat (halfPeriod) @(negedge clk);
    ssel = 1'b1;
  endtask

  // ones over the window should equal the sample word
  task automatic checkDac(input string testName, input logic [12:0] value);
    int ones;
    int waited;
    int diff;
    txBytes[0] = value[7:0];
    txBytes[1] = {3'b000, value[12:8]};   // high byte keeps bits 12..8
    spiTransfer(16'h8000 | {6'b000000, sampleLoAddr}, 2);
    repeat (2 * fetchInterval) @(negedge clk);
    repeat (dacWindow) @(negedge clk);   // let the modulator settle
    waited = 0;
    while (audio !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > audioLimit) failRun("timeout waiting for DAC window");
    end
    ones = 0;
    repeat (dacWindow) begin
      ones = ones + int'(audio);
      @(negedge clk);
    end
    diff = ones - int'(value);
    if (diff < 0) diff = -diff;
    checkEqual(testName, 32'(value), (diff <= 2) ? 32'(value) : 32'(ones));
  endtask

  initial begin
    string line;
    string testName;
    logic [8*24-1:0] nameBits;
    logic [7:0] opChar;
    logic [15:0] addr;
    logic [7:0] count;
    int fields;
    int vectors;
    sck = 1'b0;
    mosi = 1'b0;
    ssel = 1'b1;
    seed = 32'ha07d;
    vectors = 0;
    waitForReset();
    fd = $fopen("testbench/audioStimulus.txt", "r");
    if (fd == 0) failRun("cannot open testbench/audioStimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %s %h %h %h %h %h %h", nameBits, opChar, addr, count,
                         expBytes[0], expBytes[1], expBytes[2], expBytes[3]);
        if (fields != 8) begin
          failRun($sformatf("malformed stimulus line: %0s", line));
        end else begin
          testName = $sformatf("%0s", nameBits);
          vectors++;
          idleGap();
          case (opChar)
            "W": begin
              for (int i = 0; i < 4; i++) txBytes[i] = expBytes[i];
              spiTransfer(addr | 16'h8000, int'(count));
            end
            "R": begin
              for (int i = 0; i < 4; i++) txBytes[i] = 8'h00;
              spiTransfer(addr & 16'h7fff, int'(count));
              for (int i = 0; i < int'(count); i++) begin
                checkEqual($sformatf("%0s byte %0d", testName, i),
                           32'(expBytes[i]), 32'(rxBytes[i]));
              end
            end
            "D": checkDac(testName, addr[12:0]);
            default: failRun($sformatf("unknown operation in %0s", testName));
          endcase
        end
      end
    end
    $fclose(fd);
    if (vectors == 0) begin
      failRun("stimulus file holds no vectors");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: flist.f
logic/audioPkg.sv
logic/spiMemBridge.sv
logic/sharedMemory.sv
logic/sampleFetch.sv
logic/sigmaDeltaDac.sv
logic/audioTop.sv
testbench/clockGen.sv
testbench/tbAudio.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tbAudio -f flist.f -o simAudio &&
./obj_dir/simAudio | tee /dev/stderr | grep -qF "=== PASS ===" ||
{ echo "simulation did not pass"; exit 1; }

// File: testbench/audioStimulus.txt
# name op addr count b0 b1 b2 b3 (hex); W writes, R reads back and compares
# D writes the addr column as a 13-bit DAC sample and checks the output density
single_wr   W 0010 1 a5 00 00 00
single_rd   R 0010 1 a5 00 00 00
burst_wr    W 0100 4 11 22 33 44
burst_rd    R 0100 4 11 22 33 44
alias_wr    W 7c40 1 3c 00 00 00
alias_rd    R 0040 1 3c 00 00 00
alias_wr2   W 2abc 2 5a c3 00 00
alias_rd2   R 06bc 2 5a c3 00 00
dac_mid     D 1000 0 00 00 00 00
dac_low     D 0400 0 00 00 00 00
dac_high    D 1b58 0 00 00 00 00
contend_rd1 R 0100 4 11 22 33 44
contend_rd2 R 0100 4 11 22 33 44
contend_rd3 R 0100 4 11 22 33 44
contend_rd4 R 0100 4 11 22 33 44
dac_after   D 0a00 0 00 00 00 00
